// ==== Bender.yml ====
package:
  name: single_bus_cpu

sources:
  - hdl/cpuPkg.sv
  - hdl/stepCounter.sv
  - hdl/controlSequencer.sv
  - hdl/regFile.sv
  - hdl/busDatapath.sv
  - hdl/memoryApbPort.sv
  - hdl/cpuTop.sv
  - target: test
    files:
      - testbench/cpu_asserts.sv
      - testbench/tbChecker.sv
      - testbench/tbTop.sv

// ==== hdl/busDatapath.sv ====
`default_nettype none

module busDatapath (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  logic [31:0]       regBus,
    input  logic [31:0]       memRdata,
    output logic [31:0]       mar,
    output logic [31:0]       mdr,
    output cpuPkg::instr_t    instr,
    output logic [31:0]       busOut
);

    logic [31:0] pc, y, z;
    logic [31:0] cExt;

    assign cExt = {{13{instr.c[18]}}, instr.c};

    // Single shared bus, zero when nothing drives it
    always_comb begin
        if (ctrl.pcOut)       busOut = pc;
        else if (ctrl.mdrOut) busOut = mdr;
        else if (ctrl.zOut)   busOut = z;
        else if (ctrl.cOut)   busOut = cExt;
        else if (ctrl.rout)   busOut = regBus;
        else                  busOut = '0;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            instr <= '0;
        end else begin
            if (ctrl.pcIn)       pc <= busOut;
            else if (ctrl.incPc) pc <= pc + 32'd1;   // Word addressed
            if (ctrl.irIn)       instr <= busOut;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.marIn) mar <= busOut;
        if (ctrl.mdrIn) mdr <= ctrl.read ? memRdata : busOut;
        if (ctrl.yIn)   y   <= busOut;
        if (ctrl.zIn)   z   <= y + busOut;       // Y plus Rb or sign extended C
    end

endmodule

`default_nettype wire

// ==== hdl/controlSequencer.sv ====
`default_nettype none

module controlSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  cpuPkg::instr_t    instr,
    input  logic [2:0]        step,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              restart,
    output logic              advance,
    output logic              running,
    output logic              halted
);

    typedef enum logic [1:0] {stIdle, stRun, stHalted} state_t;

    state_t state, nextState;
    logic   isLd, isAddi, known;

    assign isLd   = instr.opcode == cpuPkg::opLd;
    assign isAddi = instr.opcode == cpuPkg::opAddi;
    assign known  = isLd || isAddi || instr.opcode == cpuPkg::opSt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) state <= stIdle;
        else       state <= nextState;
    end

    assign running = state == stRun;
    assign halted  = state == stHalted;

    always_comb begin
        ctrl      = '0;
        restart   = 1'b0;
        advance   = 1'b0;
        nextState = state;
        if (state == stRun) begin
            advance = 1'b1;
            case (step)
                3'd0: {ctrl.pcOut, ctrl.marIn, ctrl.incPc} = 3'b111;
                3'd1: {ctrl.read, ctrl.mdrIn} = 2'b11;
                3'd2: {ctrl.mdrOut, ctrl.irIn} = 2'b11;
                3'd3: begin
                    if (known) begin
                        {ctrl.grb, ctrl.rout, ctrl.baOut, ctrl.yIn} = 4'b1111;
                    end else begin
                        restart   = 1'b1;   // Halt or unknown opcode
                        nextState = stHalted;
                    end
                end
                3'd4: {ctrl.cOut, ctrl.zIn} = 2'b11;   // Effective address into Z
                3'd5: begin
                    ctrl.zOut = 1'b1;
                    if (isAddi) begin
                        {ctrl.gra, ctrl.rin} = 2'b11;
                        restart = 1'b1;
                    end else begin
                        ctrl.marIn = 1'b1;
                    end
                end
                3'd6: begin
                    ctrl.mdrIn = 1'b1;
                    if (isLd) ctrl.read = 1'b1;
                    else      {ctrl.gra, ctrl.rout} = 2'b11;   // Store data into MDR
                end
                default: begin
                    if (isLd) {ctrl.mdrOut, ctrl.gra, ctrl.rin} = 3'b111;
                    else      ctrl.write = 1'b1;
                    restart = 1'b1;
                end
            endcase
        end else if (start) begin
            ctrl.pcIn = 1'b1;               // Empty bus clears PC
            restart   = 1'b1;
            nextState = stRun;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Opcodes in IR[31:27], any code not listed halts the core
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opSt   = 5'd2,
        opAddi = 5'd12,
        opHalt = 5'd27
    } opcode_t;

    typedef struct packed {
        logic [4:0]         opcode;
        logic [3:0]         ra;
        logic [3:0]         rb;
        logic signed [18:0] c;      // Sign extended onto the bus by cOut
    } instr_t;

    // One bit per control line of the single-bus datapath
    typedef struct packed {
        logic pcOut;
        logic pcIn;
        logic incPc;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic irIn;
        logic yIn;
        logic zIn;
        logic zOut;
        logic cOut;
        logic read;
        logic write;
        logic gra;
        logic grb;
        logic rin;
        logic rout;
        logic baOut;
    } ctrlWord_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    // Host register map
    localparam logic [11:0] ramBase    = 12'h000;
    localparam logic [11:0] ctrlAddr   = 12'h800;  // Bit 0 starts the core
    localparam logic [11:0] statusAddr = 12'h804;  // Bit 0 running, bit 1 halted
    localparam logic [11:0] regBase    = 12'h840;  // R0..R15, read only

endpackage

`default_nettype wire

// ==== hdl/cpuTop.sv ====
`default_nettype none

module cpuTop #(
    parameter int memWords = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::apbReq_t apbReq,
    output cpuPkg::apbRsp_t apbRsp
);

    cpuPkg::ctrlWord_t ctrl;
    cpuPkg::instr_t    instr;
    logic [31:0]       dataBus, regBus, memRdata, mar, mdr, hostData;
    logic [3:0]        hostSel;
    logic [2:0]        step;
    logic              start, restart, advance, running, halted;

    stepCounter stepCounter_i (
        .clk, .rstN, .restart, .advance, .step
    );

    controlSequencer controlSequencer_i (
        .clk, .rstN, .start, .instr, .step, .ctrl, .restart, .advance, .running, .halted
    );

    regFile regFile_i (
        .clk, .rstN, .ctrl, .instr, .busIn(dataBus), .busOut(regBus), .hostSel, .hostData
    );

    busDatapath busDatapath_i (
        .clk, .rstN, .ctrl, .regBus, .memRdata, .mar, .mdr, .instr, .busOut(dataBus)
    );

    memoryApbPort #(.memWords(memWords)) memoryApbPort_i (
        .clk, .rstN, .apbReq, .apbRsp, .ctrl, .mar, .mdr, .memRdata,
        .running, .halted, .start, .hostSel, .hostData
    );

endmodule

`default_nettype wire

// ==== hdl/memoryApbPort.sv ====
`default_nettype none

module memoryApbPort #(
    parameter int memWords = 256
) (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::apbReq_t   apbReq,
    output cpuPkg::apbRsp_t   apbRsp,
    input  cpuPkg::ctrlWord_t ctrl,
    input  logic [31:0]       mar,
    input  logic [31:0]       mdr,
    output logic [31:0]       memRdata,
    input  logic              running,
    input  logic              halted,
    output logic              start,
    output logic [3:0]        hostSel,
    input  logic [31:0]       hostData
);

    localparam int addrBits = $clog2(memWords);

    logic [31:0]         ram [memWords];
    logic [addrBits-1:0] hostIdx;
    logic                hostWr, isRam, isCtrl, isStatus, isReg;

    assign hostWr   = apbReq.psel && apbReq.penable && apbReq.pwrite;   // Access phase
    assign isRam    = 32'(apbReq.paddr - cpuPkg::ramBase) < memWords * 4;
    assign isCtrl   = apbReq.paddr == cpuPkg::ctrlAddr;
    assign isStatus = apbReq.paddr == cpuPkg::statusAddr;
    assign isReg    = apbReq.paddr[11:6] == cpuPkg::regBase[11:6];
    assign hostIdx  = apbReq.paddr[addrBits+1:2];
    assign hostSel  = apbReq.paddr[5:2];

    assign memRdata = ram[mar[addrBits-1:0]];   // CPU read within its step

    // Host writes only land while the core is stopped
    always_ff @(posedge clk) begin
        if (ctrl.write) ram[mar[addrBits-1:0]] <= mdr;
        else if (hostWr && isRam && !running) ram[hostIdx] <= apbReq.pwdata;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) start <= 1'b0;
        else       start <= hostWr && isCtrl && apbReq.pwdata[0];
    end

    always_comb begin
        apbRsp.prdata = '0;
        if (isRam)         apbRsp.prdata = ram[hostIdx];
        else if (isStatus) apbRsp.prdata = {30'd0, halted, running};
        else if (isReg)    apbRsp.prdata = hostData;
    end

    assign apbRsp.pready  = 1'b1;              // No wait states
    assign apbRsp.pslverr = hostWr && ((isRam && running) || isReg ||
                                       !(isRam || isCtrl || isStatus));

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::instr_t    instr,
    input  logic [31:0]       busIn,
    output logic [31:0]       busOut,
    input  logic [3:0]        hostSel,
    output logic [31:0]       hostData
);

    logic [31:0] regs [16];
    logic [3:0]  sel;

    // Ra or Rb field picks the register
    always_comb begin
        sel = 4'd0;
        if (ctrl.gra)      sel = instr.ra;
        else if (ctrl.grb) sel = instr.rb;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rin) begin
            regs[sel] <= busIn;
        end
    end

    // R0 as a base register reads as zero
    always_comb begin
        busOut = '0;
        if (ctrl.rout && !(ctrl.baOut && sel == 4'd0)) busOut = regs[sel];
    end

    assign hostData = regs[hostSel];

endmodule

`default_nettype wire

// ==== hdl/stepCounter.sv ====
`default_nettype none

// Control step T0..T7 of the current instruction
module stepCounter (
    input  logic       clk,
    input  logic       rstN,
    input  logic       restart,
    input  logic       advance,
    output logic [2:0] step
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step <= 3'd0;
        end else if (restart) begin
            step <= 3'd0;                   // Restart wins over advance
        end else if (advance) begin
            step <= step + 3'd1;            // Wraps after T7
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/cpuPkg.sv
hdl/stepCounter.sv
hdl/controlSequencer.sv
hdl/regFile.sv
hdl/busDatapath.sv
hdl/memoryApbPort.sv
hdl/cpuTop.sv
testbench/cpu_asserts.sv
testbench/tbChecker.sv
testbench/tbTop.sv

// ==== testbench/cpu_asserts.sv ====
`default_nettype none

// Bound into controlSequencer
module cpuAsserts (
    input logic              clk,
    input logic              rstN,
    input cpuPkg::ctrlWord_t ctrl,
    input logic [2:0]        step,
    input logic              halted
);

    int failures = 0;

    // One memory direction per step
    assert property (@(posedge clk) disable iff (!rstN) !(ctrl.read && ctrl.write))
        else begin
            $error("read and write set in the same step");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rstN) halted |-> step < 3'd4)
        else begin
            $error("step counter moved on after halt");
            failures++;
        end

endmodule

bind controlSequencer cpuAsserts cpuAsserts_i (
    .clk(clk), .rstN(rstN), .ctrl(ctrl), .step(step), .halted(halted)
);

`default_nettype wire

// ==== testbench/tbChecker.sv ====
`default_nettype none

// Compares every APB access phase with what tbTop expects
module tbChecker (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::apbReq_t apbReq,
    input  cpuPkg::apbRsp_t apbRsp,
    input  logic [31:0]     expData,
    input  logic            expDataOn,
    input  logic            expErr
);

    int checks = 0;
    int errors = 0;
    int tests = 0;
    int testChecks = 0;
    int testErrors = 0;

    always @(posedge clk) begin
        if (rstN && apbReq.psel && apbReq.penable) begin
            checks++;
            testChecks++;
            if (apbRsp.pready !== 1'b1) begin
                errors++;
                testErrors++;
                $display("Mismatch pready at 0x%03h: expected 0x1, got 0x%0h",
                         apbReq.paddr, apbRsp.pready);
            end
            if (apbRsp.pslverr !== expErr) begin
                errors++;
                testErrors++;
                $display("Mismatch pslverr at 0x%03h: expected 0x%0h, got 0x%0h",
                         apbReq.paddr, expErr, apbRsp.pslverr);
            end
            if (expDataOn && apbRsp.prdata !== expData) begin
                errors++;
                testErrors++;
                if (apbReq.paddr >= cpuPkg::regBase)          // R0..R15 window
                    $display("Mismatch R%0d: expected 0x%08h, got 0x%08h",
                             apbReq.paddr[5:2], expData, apbRsp.prdata);
                else if (apbReq.paddr == cpuPkg::statusAddr)
                    $display("Mismatch status: expected 0x%08h, got 0x%08h",
                             expData, apbRsp.prdata);
                else
                    $display("Mismatch mem[0x%02h]: expected 0x%08h, got 0x%08h",
                             apbReq.paddr[9:2], expData, apbRsp.prdata);
            end
        end
    end

    task automatic finishTest(input string name);
        $display("Test %s: %0d checks, %0d errors, %s", name, testChecks, testErrors,
                 testErrors == 0 ? "ok" : "failed");
        tests++;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic summary();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

endmodule

`default_nettype wire

// ==== testbench/tbTop.sv ====
`default_nettype none

module tbTop;

    localparam int memWords   = 256;
    localparam int numProgs   = 13;        // Programs run over all tests
    localparam int maxInstr   = 20;        // Four base setups, up to 15 body words, halt
    localparam int apbPerProg = 180;       // Loads, start, checks, three cycles each
    localparam int cycleLimit = numProgs * (maxInstr * 8 + apbPerProg * 3) + 300;

    logic            clk, rstN;
    cpuPkg::apbReq_t apbReq;
    cpuPkg::apbRsp_t apbRsp;
    logic [31:0]     expData, seed;
    logic            expDataOn, expErr;
    logic [31:0]     mRegs [16];           // Reference machine state
    logic [31:0]     mMem [memWords];
    int              cycles;

    cpuTop #(.memWords(memWords)) dut_i (.clk, .rstN, .apbReq, .apbRsp);

    tbChecker checker_i (.clk, .rstN, .apbReq, .apbRsp, .expData, .expDataOn, .expErr);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Setup phase, then access phase, then idle
    task automatic apbAccess(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                             input logic [31:0] exp, input logic chk, input logic err,
                             output logic [31:0] rdata);
        @(negedge clk);
        apbReq    = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        expData   = exp;
        expDataOn = chk;
        expErr    = err;
        @(negedge clk);
        apbReq.penable = 1'b1;
        @(posedge clk);
        rdata = apbRsp.prdata;
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] unused;
        apbAccess(1'b1, addr, data, '0, 1'b0, err, unused);
    endtask

    task automatic apbRead(input logic [11:0] addr, input logic [31:0] exp, input logic chk,
                           output logic [31:0] data);
        apbAccess(1'b0, addr, '0, exp, chk, 1'b0, data);
    endtask

    // ISA rules: R0 as base reads zero, any unknown opcode halts
    task automatic runModel();
        cpuPkg::instr_t ins;
        logic [31:0]    pc, ea;
        logic           done;
        pc   = '0;
        done = 1'b0;
        while (!done) begin
            ins = mMem[pc[7:0]];
            pc++;
            ea = (ins.rb == 4'd0 ? 32'd0 : mRegs[ins.rb]) + {{13{ins.c[18]}}, ins.c};
            case (ins.opcode)
                cpuPkg::opLd:   mRegs[ins.ra] = mMem[ea[7:0]];
                cpuPkg::opSt:   mMem[ea[7:0]] = mRegs[ins.ra];
                cpuPkg::opAddi: mRegs[ins.ra] = ea;
                default:        done = 1'b1;
            endcase
        end
    endtask

    // kind 0 is ld/st, 1 is addi chain, 2 is addi chain with an unknown opcode
    task automatic runProgram(input int kind, input logic reload, input logic intrude);
        cpuPkg::instr_t ins;
        logic [31:0]    r, st;
        int             n, count;
        if (reload) begin
            n = 0;
            if (kind == 0) begin
                for (int b = 1; b < 5; b++) begin   // Bases R1..R4 from R0
                    mMem[n] = {cpuPkg::opAddi, 4'(b), 4'd0, 19'h90 + 19'(nextRand() % 16)};
                    n++;
                end
            end
            count = 8 + nextRand() % 8;
            for (int k = 0; k < count; k++) begin
                r          = nextRand();
                ins        = r;
                ins.opcode = cpuPkg::opAddi;
                if (kind == 0) begin
                    ins.opcode = r[0] ? cpuPkg::opLd : cpuPkg::opSt;
                    ins.ra     = r[7:4] > 4'd4 ? r[7:4] : 4'd0;   // Bases stay intact
                    ins.rb     = r[12:10] == 3'd0 ? 4'd0 : {2'b00, r[9:8]} + 4'd1;
                    // Effective address always lands in data words 0x80..0xBF
                    ins.c = ins.rb == 4'd0 ? 19'h80 + 19'(r[21:16])
                                           : 19'(r[21:16] % 48) - 19'd16;
                end else if (kind == 2 && k == count / 2) begin
                    ins.opcode = r[31:27];
                    if (ins.opcode == cpuPkg::opLd || ins.opcode == cpuPkg::opSt ||
                        ins.opcode == cpuPkg::opAddi || ins.opcode == cpuPkg::opHalt) begin
                        ins.opcode = 5'd9;
                    end
                end
                mMem[n] = ins;
                n++;
            end
            mMem[n] = {cpuPkg::opHalt, 27'd0};
            n++;
            for (int a = 'h80; a < 'hC0; a++) mMem[a] = nextRand();
            for (int a = 0; a < n; a++) apbWrite(12'(a * 4), mMem[a], 1'b0);
            for (int a = 'h80; a < 'hC0; a++) apbWrite(12'(a * 4), mMem[a], 1'b0);
        end
        apbWrite(cpuPkg::ctrlAddr, 32'h1, 1'b0);
        if (intrude) begin
            do apbRead(cpuPkg::statusAddr, '0, 1'b0, st); while (!st[0]);
            apbWrite(12'h280, ~mMem['hA0], 1'b1);       // Word 0xA0 must stay
        end
        do apbRead(cpuPkg::statusAddr, '0, 1'b0, st); while (st[1:0] != 2'b10);
        runModel();
        apbRead(cpuPkg::statusAddr, 32'h2, 1'b1, st);
        for (int i = 0; i < 16; i++) apbRead(cpuPkg::regBase + 12'(i * 4), mRegs[i], 1'b1, st);
        for (int a = 'h80; a < 'hC0; a++) apbRead(12'(a * 4), mMem[a], 1'b1, st);
    endtask

    initial begin
        logic [31:0] d;
        seed      = 32'h2ce6503e;
        apbReq    = '0;
        expData   = '0;
        expDataOn = 1'b0;
        expErr    = 1'b0;
        for (int i = 0; i < 16; i++) mRegs[i] = '0;
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        apbRead(cpuPkg::statusAddr, 32'h0, 1'b1, d);
        for (int i = 0; i < 16; i++) apbRead(cpuPkg::regBase + 12'(i * 4), 32'h0, 1'b1, d);
        apbWrite(12'h400, 32'h1, 1'b1);                 // Unmapped
        apbWrite(12'h900, 32'h1, 1'b1);
        apbWrite(cpuPkg::regBase + 12'h14, 32'h1, 1'b1); // Register window is read only
        checker_i.finishTest("reset");
        repeat (4) runProgram(0, 1'b1, 1'b0);
        checker_i.finishTest("load and store");
        repeat (4) runProgram(1, 1'b1, 1'b0);
        checker_i.finishTest("addi chains");
        runProgram(2, 1'b1, 1'b0);
        checker_i.finishTest("unknown opcode");
        runProgram(1, 1'b1, 1'b1);
        checker_i.finishTest("host write while running");
        runProgram(1, 1'b1, 1'b0);
        runProgram(1, 1'b0, 1'b0);                      // Same program, registers carried
        runProgram(1, 1'b0, 1'b0);
        checker_i.finishTest("restart");

        checker_i.summary();
        if (checker_i.errors == 0 &&
            dut_i.controlSequencer_i.cpuAsserts_i.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
